// ==== dv/psram_testdata.txt ====
# name, op, hex address, byte count, hex bytes (expected values for R lines).
# op W writes, R reads and checks, X sends command 9F, A stops a write after one nibble.
write_base    W 000100 8 11 22 33 44 55 66 77 88
read_base     R 000100 8 11 22 33 44 55 66 77 88
read_middle   R 000103 4 44 55 66 77
write_wrap    W 0003FE 4 A1 B2 C3 D4
read_wrap_top R 0003FE 2 A1 B2
read_wrap_low R 000000 2 C3 D4
read_upper    R 5A0000 2 C3 D4
read_across   R 0003FF 3 B2 C3 D4
unknown_cmd   X 000100 4 DE AD BE EF
read_after_x  R 000100 4 11 22 33 44
abort_nibble  A 000102 1 F0
read_after_ab R 000101 3 22 33 44
write_second  W 000108 3 5A A5 3C
read_second   R 000106 5 77 88 5A A5 3C

// ==== vlog.f ====
src/psram_pkg.sv
src/psram_mem_array.sv
src/psram_cmd_decoder.sv
src/psram_read_path.sv
src/psram_write_path.sv
src/psram_top.sv
dv/tb_psram.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_psram
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

// ==== dv/tb_psram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_psram;

  localparam int POLL_LIMIT  = 20; // polls are 2 ns apart, so about five clock periods.
  localparam int IDLE_CYCLES = 16;
  localparam int MAX_BYTES   = 16;
  localparam int MAX_TESTS   = 64;
  localparam logic [7:0] CMD_UNKNOWN = 8'h9F;

  logic            sck;
  logic            ce_n;
  logic            host_oe;
  logic [3:0]      host_dio;
  wire  [3:0]      dio;
  int unsigned     cycles = 0;
  logic            timed_out = 1'b0;
  logic            test_err;
  int              pass_count;
  int              fail_count;
  logic [8*16-1:0] name;
  logic [7:0]      op;
  logic [23:0]     addr;
  int              count;
  logic [7:0]      data [MAX_BYTES];

  assign dio = host_oe ? host_dio : 4'bz; // host side of the shared lines.

  psram_top i_dut (
    .sck  (sck),
    .ce_n (ce_n),
    .dio  (dio)
  );

  initial begin
    sck = 1'b0;
    forever begin
      #4 sck = ~sck;
    end
  end

  always @(posedge sck) begin
    cycles <= cycles + 1;
  end

  // polls on odd times only, so it returns 1 ns after the rising edge.
  task automatic next_rise();
    int unsigned start;
    int          polls;
    if (!timed_out) begin
      start = cycles;
      polls = 0;
      while (cycles == start && polls < POLL_LIMIT) begin
        #2;
        polls++;
      end
      if (cycles == start) begin
        $display("timeout: no rising edge on sck within %0d ns", 2 * POLL_LIMIT);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic idle_bus();
    int i;
    ce_n    = 1'b1;
    host_oe = 1'b0;
    for (i = 0; i < IDLE_CYCLES; i++) begin
      next_rise();
    end
  endtask

  task automatic check_released();
    assert (i_dut.dio_oe === 1'b0) else begin
      $display("test %0s: DUT drives dio while the lines must be released", name);
      test_err = 1'b1;
    end
  endtask

  // command bits on dio[0], then six address nibbles, most significant first.
  task automatic send_header(input logic [7:0] cmd);
    int i;
    ce_n     = 1'b0;
    host_oe  = 1'b1;
    host_dio = {3'b000, cmd[7]};
    for (i = 6; i >= 0; i--) begin
      next_rise();
      host_dio = {3'b000, cmd[i]};
    end
    for (i = 5; i >= 0; i--) begin
      next_rise();
      host_dio = addr[4*i +: 4];
    end
  endtask

  task automatic write_burst(input logic [7:0] cmd, input int nibbles);
    int k;
    send_header(cmd);
    for (k = 0; k < nibbles; k++) begin
      next_rise();
      host_dio = k[0] ? data[k/2][3:0] : data[k/2][7:4];
      check_released();
    end
    next_rise(); // the last nibble is sampled here.
    if (nibbles % 2 == 0) begin
      next_rise(); // and the last byte is stored one edge later.
    end
  endtask

  task automatic read_burst();
    int         k;
    logic [3:0] hi;
    logic [3:0] lo;
    send_header(psram_pkg::CMD_READ);
    next_rise();
    host_oe = 1'b0;
    for (k = 0; k < psram_pkg::READ_WAIT; k++) begin
      #6;
      check_released();
      next_rise();
    end
    for (k = 0; k < count; k++) begin
      #6 hi = dio;
      next_rise();
      #6 lo = dio;
      next_rise();
      assert ({hi, lo} === data[k]) else begin
        $display("** Error %0s: byte %0d expected %02h, actual %02h", name, k, data[k], {hi, lo});
        test_err = 1'b1;
      end
    end
  endtask

  initial begin
    int              fd;
    int              code;
    int              i;
    int              tests;
    logic            done;
    logic [7:0]      byte_val;
    logic [8*128-1:0] rest;
    ce_n       = 1'b1;
    host_oe    = 1'b0;
    host_dio   = 4'h0;
    pass_count = 0;
    fail_count = 0;
    tests      = 0;
    done       = 1'b0;
    #1;
    idle_bus();
    fd = $fopen("dv/psram_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/psram_testdata.txt");
      fail_count++;
      done = 1'b1;
    end
    while (!done && !timed_out && tests < MAX_TESTS) begin
      code = $fscanf(fd, "%s", name);
      if (code != 1) begin
        done = 1'b1;
      end else if (name == {{15{8'h00}}, "#"}) begin
        code = $fgets(rest, fd); // comment line.
      end else begin
        tests++;
        test_err = 1'b0;
        code = $fscanf(fd, "%s %h %d", op, addr, count);
        if (code != 3 || count < 1 || count > MAX_BYTES) begin
          $display("test %0s: the data file line is malformed", name);
          test_err = 1'b1;
          done     = 1'b1;
        end else begin
          for (i = 0; i < count; i++) begin
            code = $fscanf(fd, "%h", byte_val);
            data[i] = byte_val;
          end
          case (op)
            "W": write_burst(psram_pkg::CMD_WRITE, 2 * count);
            "A": write_burst(psram_pkg::CMD_WRITE, 1);
            "X": write_burst(CMD_UNKNOWN, 2 * count);
            "R": read_burst();
            default: begin
              $display("test %0s: unknown operation %0s", name, op);
              test_err = 1'b1;
            end
          endcase
          idle_bus();
        end
        if (test_err || timed_out) begin
          fail_count++;
          $display("%0s: failed", name);
        end else begin
          pass_count++;
          $display("%0s: passed", name);
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/psram_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module psram_top (
  input  wire       sck,
  input  wire       ce_n,
  inout  wire [3:0] dio
);

  logic [3:0]                       dio_in;
  logic [3:0]                       dio_out;
  logic                             dio_oe;
  logic                             rd_phase;
  logic                             wr_phase;
  logic [psram_pkg::MEM_ADDR_W-1:0] start_addr;
  logic [psram_pkg::MEM_ADDR_W-1:0] rd_addr;
  logic [7:0]                       rd_data;
  logic                             wr_en;
  logic [psram_pkg::MEM_ADDR_W-1:0] wr_addr;
  logic [7:0]                       wr_data;

  assign dio_in = dio;
  assign dio    = dio_oe ? dio_out : 4'bz; // only the read path ever drives the pins.

  psram_cmd_decoder i_cmd_decoder (
    .sck        (sck),
    .ce_n       (ce_n),
    .dio_in     (dio_in),
    .rd_phase   (rd_phase),
    .wr_phase   (wr_phase),
    .start_addr (start_addr)
  );

  psram_read_path i_read_path (
    .sck        (sck),
    .ce_n       (ce_n),
    .rd_phase   (rd_phase),
    .start_addr (start_addr),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .dio_out    (dio_out),
    .dio_oe     (dio_oe)
  );

  psram_write_path i_write_path (
    .sck        (sck),
    .ce_n       (ce_n),
    .wr_phase   (wr_phase),
    .start_addr (start_addr),
    .dio_in     (dio_in),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data)
  );

  psram_mem_array i_mem_array (
    .sck     (sck),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// ==== src/psram_write_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module psram_write_path (
  input  logic                             sck,
  input  logic                             ce_n,
  input  logic                             wr_phase,
  input  logic [psram_pkg::MEM_ADDR_W-1:0] start_addr,
  input  logic [3:0]                       dio_in,
  output logic                             wr_en,
  output logic [psram_pkg::MEM_ADDR_W-1:0] wr_addr,
  output logic [7:0]                       wr_data
);

  logic                             half;
  logic [3:0]                       hi_nib;
  logic [psram_pkg::MEM_ADDR_W-1:0] wr_ofs;

  assign wr_addr = start_addr + wr_ofs; // wraps modulo the array depth.

  always_ff @(posedge sck or posedge ce_n) begin
    if (ce_n) begin
      half   <= 1'b0;
      wr_en  <= 1'b0;
      wr_ofs <= '0;
    end else begin
      wr_en <= wr_phase & half; // one-cycle strobe per completed byte.
      if (wr_en) begin
        wr_ofs <= wr_ofs + 1'b1;
      end
      if (wr_phase) begin
        half <= ~half;
      end
    end
  end

  // a byte cut short by ce_n never reaches wr_data with a strobe.
  always_ff @(posedge sck) begin
    if (wr_phase) begin
      if (!half) begin
        hi_nib <= dio_in;
      end else begin
        wr_data <= {hi_nib, dio_in};
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/psram_read_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module psram_read_path (
  input  logic                             sck,
  input  logic                             ce_n,
  input  logic                             rd_phase,
  input  logic [psram_pkg::MEM_ADDR_W-1:0] start_addr,
  output logic [psram_pkg::MEM_ADDR_W-1:0] rd_addr,
  input  logic [7:0]                       rd_data,
  output logic [3:0]                       dio_out,
  output logic                             dio_oe
);

  logic [psram_pkg::CNT_W-1:0]      wait_cnt;
  logic [psram_pkg::MEM_ADDR_W-1:0] rd_ofs;
  logic                             nib_hi;
  logic                             wait_done;
  logic                             load_byte;
  logic [7:0]                       byte_q;

  assign wait_done = (int'(wait_cnt) == psram_pkg::READ_WAIT - 1);

  // first fetch ends the wait, later fetches follow each low nibble.
  assign load_byte = dio_oe ? ~nib_hi : (rd_phase & wait_done);

  // the offset wraps on its own width, so the address stays in the array.
  assign rd_addr = start_addr + rd_ofs;

  always_ff @(posedge sck or posedge ce_n) begin
    if (ce_n) begin
      wait_cnt <= '0;
      rd_ofs   <= '0;
      nib_hi   <= 1'b0;
      dio_oe   <= 1'b0;
    end else begin
      if (!dio_oe && rd_phase && !wait_done) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
      if (load_byte) begin
        dio_oe <= 1'b1; // stays on until ce_n rises.
        rd_ofs <= rd_ofs + 1'b1;
        nib_hi <= 1'b1;
      end else if (dio_oe) begin
        nib_hi <= 1'b0;
      end
    end
  end

  always_ff @(posedge sck) begin
    if (load_byte) begin
      byte_q <= rd_data;
    end
  end

  assign dio_out = nib_hi ? byte_q[7:4] : byte_q[3:0]; // high nibble goes out first.

endmodule

`default_nettype wire

// ==== src/psram_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module psram_cmd_decoder (
  input  logic                             sck,
  input  logic                             ce_n,
  input  logic [3:0]                       dio_in,
  output logic                             rd_phase,
  output logic                             wr_phase,
  output logic [psram_pkg::MEM_ADDR_W-1:0] start_addr
);

  psram_pkg::phase_e             phase;
  logic [psram_pkg::CNT_W-1:0]   cnt;
  psram_pkg::psram_header_u      hdr;
  psram_pkg::psram_header_u      hdr_next;
  logic                          cmd_last;
  logic                          addr_last;

  assign cmd_last  = (int'(cnt) == psram_pkg::CMD_CYCLES - 1);
  assign addr_last = (int'(cnt) == psram_pkg::ADDR_CYCLES - 1);

  // command bits come in on dio[0] only, address nibbles on all four lines.
  always_comb begin
    hdr_next = hdr;
    if (phase == psram_pkg::PH_CMD) begin
      hdr_next.raw = {hdr.raw[30:0], dio_in[0]};
    end else if (phase == psram_pkg::PH_ADDR) begin
      hdr_next.raw = {hdr.raw[27:0], dio_in};
    end
  end

  always_ff @(posedge sck) begin
    hdr <= hdr_next; // holds once the address phase is over.
  end

  always_ff @(posedge sck or posedge ce_n) begin
    if (ce_n) begin
      phase <= psram_pkg::PH_CMD;
      cnt   <= '0;
    end else begin
      case (phase)
        psram_pkg::PH_CMD: begin
          if (cmd_last) begin
            cnt   <= '0;
            phase <= psram_pkg::PH_ADDR;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        psram_pkg::PH_ADDR: begin
          if (addr_last) begin
            cnt <= '0;
            // decode from the word as it stands after this last nibble.
            if (hdr_next.fields.cmd == psram_pkg::CMD_READ) begin
              phase <= psram_pkg::PH_READ;
            end else if (hdr_next.fields.cmd == psram_pkg::CMD_WRITE) begin
              phase <= psram_pkg::PH_WRITE;
            end else begin
              phase <= psram_pkg::PH_IDLE;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          phase <= phase; // stay put until ce_n ends the transaction.
        end
      endcase
    end
  end

  assign rd_phase   = (phase == psram_pkg::PH_READ);
  assign wr_phase   = (phase == psram_pkg::PH_WRITE);
  assign start_addr = hdr.fields.addr[psram_pkg::MEM_ADDR_W-1:0]; // upper bits ignored.

endmodule

`default_nettype wire

// ==== src/psram_mem_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module psram_mem_array (
  input  logic                             sck,
  input  logic                             wr_en,
  input  logic [psram_pkg::MEM_ADDR_W-1:0] wr_addr,
  input  logic [7:0]                       wr_data,
  input  logic [psram_pkg::MEM_ADDR_W-1:0] rd_addr,
  output logic [7:0]                       rd_data
);

  // contents survive ce_n, so data carries over between transactions.
  logic [7:0] mem [psram_pkg::MEM_DEPTH];

  always_ff @(posedge sck) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  assign rd_data = mem[rd_addr]; // sampled by the read path at the byte boundary.

endmodule

`default_nettype wire

// ==== src/psram_pkg.sv ====
`default_nettype none

package psram_pkg;

  // header layout
  localparam int CMD_W  = 8;
  localparam int ADDR_W = 24;

  // command codes
  localparam logic [CMD_W-1:0] CMD_WRITE = 8'h38; // quad write.
  localparam logic [CMD_W-1:0] CMD_READ  = 8'hEB; // quad fast read.

  // phase lengths in sck cycles
  localparam int CMD_CYCLES  = 8;  // one command bit per cycle on dio[0].
  localparam int ADDR_CYCLES = 6;  // one address nibble per cycle.
  localparam int READ_WAIT   = 6;  // dummy cycles before the first read nibble.

  // width of the small phase and wait counters.
  localparam int CNT_W = 3;

  // internal storage
  localparam int MEM_ADDR_W = 10;
  localparam int MEM_DEPTH  = 1024;

  // PH_IDLE parks an unknown command until ce_n rises.
  typedef enum logic [2:0] {
    PH_CMD   = 3'd0,
    PH_ADDR  = 3'd1,
    PH_READ  = 3'd2,
    PH_WRITE = 3'd3,
    PH_IDLE  = 3'd4
  } phase_e;

  // the header is shifted in as one raw word and decoded as fields.
  typedef union packed {
    logic [CMD_W+ADDR_W-1:0] raw;
    struct packed {
      logic [CMD_W-1:0]  cmd;  // arrives first, ends up on top.
      logic [ADDR_W-1:0] addr;
    } fields;
  } psram_header_u;

endpackage

`default_nettype wire
